/* ecc_pkg.sv */
package ecc_pkg;

    // ******************************************************************
    // Code geometry
    // ******************************************************************
    localparam int DATA_WIDTH   = 126;
    localparam int PARITY_WIDTH = 9;
    // Hamming position field, the low syndrome bits
    localparam int POS_WIDTH    = PARITY_WIDTH - 1;

    // Flow control defaults
    localparam int DEFAULT_IN_CREDITS  = 4;
    localparam int DEFAULT_OUT_CREDITS = 2;

    typedef logic [DATA_WIDTH-1:0]   ecc_data_t;
    typedef logic [PARITY_WIDTH-1:0] ecc_parity_t;
    typedef logic [POS_WIDTH-1:0]    ecc_pos_t;

    // One stored word as read back from memory
    typedef struct packed {
        ecc_data_t   data;
        ecc_parity_t parity;
        logic        bypass;
    } ecc_read_t;

    // One checked word
    typedef struct packed {
        ecc_data_t data;
        logic      sbit_err;
        logic      dbit_err;
    } ecc_result_t;

    // ******************************************************************
    // Syndrome column of data bit idx
    // ******************************************************************
    // Positions start at 3 and skip every power of two on the way up
    function automatic ecc_parity_t data_column(input int unsigned idx);
        ecc_pos_t pos;
        pos = ecc_pos_t'(idx + 3);
        for (int k = 2; k < POS_WIDTH; k++) begin
            if (pos >= ecc_pos_t'(1 << k)) begin
                pos = pos + ecc_pos_t'(1);
            end
        end
        // Top bit makes every column odd weight
        return {~^pos, pos};
    endfunction

endpackage

/* ecc_encoder.sv */
`timescale 1ns/1ps

module ecc_encoder (
    input  ecc_pkg::ecc_data_t   data,
    output ecc_pkg::ecc_parity_t parity
);

    // Each set data bit toggles the check bits named by its column
    always_comb begin
        parity = '0;
        for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
            if (data[i]) begin
                parity = parity ^ ecc_pkg::data_column(i);
            end
        end
    end

endmodule

/* ecc_syndrome_decoder.sv */
`timescale 1ns/1ps

module ecc_syndrome_decoder (
    input  ecc_pkg::ecc_parity_t syndrome,
    output ecc_pkg::ecc_data_t   mask,
    output logic                 sbit_err,
    output logic                 dbit_err
);

    logic       col_hit;
    logic [3:0] weight;

    // Match the syndrome against every data column
    always_comb begin
        mask    = '0;
        col_hit = 1'b0;
        for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
            if (syndrome == ecc_pkg::data_column(i)) begin
                mask[i] = 1'b1;
                col_hit = 1'b1;
            end
        end
    end

    // Weight one means a flipped check bit
    always_comb begin
        weight = '0;
        for (int k = 0; k < ecc_pkg::PARITY_WIDTH; k++) begin
            weight = weight + 4'(syndrome[k]);
        end
    end

    // ******************************************************************
    // Classification
    // ******************************************************************
    always_comb begin
        sbit_err = 1'b0;
        dbit_err = 1'b0;
        if (syndrome != '0) begin
            if (col_hit || weight == 4'd1) begin
                sbit_err = 1'b1;
            end else begin
                // even weight or an unused odd column
                dbit_err = 1'b1;
            end
        end
    end

endmodule

/* ecc_credit_fifo.sv */
`timescale 1ns/1ps

module ecc_credit_fifo #(
    parameter int DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  ecc_pkg::ecc_read_t in_word,
    input  logic              pop,
    output logic              pop_valid,
    output ecc_pkg::ecc_read_t pop_word,
    output logic              in_credit
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    ecc_pkg::ecc_read_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          rd_fire;

    // ******************************************************************
    // Read side, first word falls through
    // ******************************************************************
    assign pop_valid = (count != '0);
    assign pop_word  = mem[rd_ptr];
    assign rd_fire   = pop & pop_valid;

    // Every word leaving frees one upstream slot
    assign in_credit = rd_fire;

    // Storage
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_word;
        end
    end

    // ******************************************************************
    // Pointers and occupancy
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
            end
            case ({in_valid, rd_fire})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

/* ecc_check_pipe.sv */
`timescale 1ns/1ps

module ecc_check_pipe #(
    parameter int OUT_CREDITS = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pop_valid,
    input  ecc_pkg::ecc_read_t   pop_word,
    output logic                 pop,
    input  logic                 out_credit,
    output logic                 out_valid,
    output ecc_pkg::ecc_result_t out_result
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [CW-1:0] credit_cnt;

    ecc_pkg::ecc_parity_t recalc_parity;

    // Stage 1 registers
    logic                 s1_valid;
    ecc_pkg::ecc_data_t   s1_data;
    logic                 s1_bypass;
    ecc_pkg::ecc_parity_t s1_syndrome;

    ecc_pkg::ecc_data_t dec_mask;
    logic               dec_sbit;
    logic               dec_dbit;

    // ******************************************************************
    // Downstream credits
    // ******************************************************************
    assign pop = pop_valid & (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CW'(OUT_CREDITS);
        end else begin
            case ({pop, out_credit})
                2'b10:   credit_cnt <= credit_cnt - CW'(1);
                2'b01:   credit_cnt <= credit_cnt + CW'(1);
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // ******************************************************************
    // Stage 1, syndrome
    // ******************************************************************
    ecc_encoder recalc_inst (
        .data   (pop_word.data),
        .parity (recalc_parity)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        s1_data     <= pop_word.data;
        s1_bypass   <= pop_word.bypass;
        s1_syndrome <= pop_word.parity ^ recalc_parity;
    end

    // ******************************************************************
    // Stage 2, correction
    // ******************************************************************
    ecc_syndrome_decoder decoder_inst (
        .syndrome (s1_syndrome),
        .mask     (dec_mask),
        .sbit_err (dec_sbit),
        .dbit_err (dec_dbit)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    // Bypassed words pass untouched with no flags
    always_ff @(posedge clk) begin
        out_result.data     <= s1_bypass ? s1_data : (s1_data ^ dec_mask);
        out_result.sbit_err <= ~s1_bypass & dec_sbit;
        out_result.dbit_err <= ~s1_bypass & dec_dbit;
    end

endmodule

/* ecc_126_top.sv */
`timescale 1ns/1ps

module ecc_126_top #(
    parameter int IN_CREDITS  = ecc_pkg::DEFAULT_IN_CREDITS,
    parameter int OUT_CREDITS = ecc_pkg::DEFAULT_OUT_CREDITS
) (
    input  logic                 clk,
    input  logic                 reset,

    // Write side encode
    input  ecc_pkg::ecc_data_t   wr_data,
    output ecc_pkg::ecc_parity_t wr_parity,

    // Read words in
    input  logic                 in_valid,
    input  ecc_pkg::ecc_read_t   in_word,
    output logic                 in_credit,

    // Checked words out
    input  logic                 out_credit,
    output logic                 out_valid,
    output ecc_pkg::ecc_result_t out_result
);

    logic               pop;
    logic               pop_valid;
    ecc_pkg::ecc_read_t pop_word;

    // ******************************************************************
    // Write path
    // ******************************************************************
    ecc_encoder wr_encoder_inst (
        .data   (wr_data),
        .parity (wr_parity)
    );

    // ******************************************************************
    // Read path
    // ******************************************************************
    ecc_credit_fifo #(
        .DEPTH (IN_CREDITS)
    ) in_fifo_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .pop       (pop),
        .pop_valid (pop_valid),
        .pop_word  (pop_word),
        .in_credit (in_credit)
    );

    ecc_check_pipe #(
        .OUT_CREDITS (OUT_CREDITS)
    ) check_pipe_inst (
        .clk        (clk),
        .reset      (reset),
        .pop_valid  (pop_valid),
        .pop_word   (pop_word),
        .pop        (pop),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

/* ecc_126_top_sva.sv */
`timescale 1ns/1ps

module ecc_126_top_sva #(
    parameter int DEPTH   = 4,
    parameter int CREDITS = 2
) (
    input logic                 clk,
    input logic                 reset,
    input logic                 in_valid,
    input logic                 in_credit,
    input logic                 out_valid,
    input ecc_pkg::ecc_result_t out_result
);

    // Words held in the input buffer
    int fill;
    // Popped words not yet delivered
    int in_flight;

    always_ff @(posedge clk) begin
        if (reset) begin
            fill      <= 0;
            in_flight <= 0;
        end else begin
            fill      <= fill + int'(in_valid) - int'(in_credit);
            in_flight <= in_flight + int'(in_credit) - int'(out_valid);
        end
    end

    // ******************************************************************
    // Protocol properties
    // ******************************************************************
    no_write_when_full: assert property (
        @(posedge clk) disable iff (reset) in_valid |-> fill < DEPTH
    ) else $error("Word written into a full input buffer");

    result_has_credit: assert property (
        @(posedge clk) disable iff (reset) out_valid |-> in_flight > 0
    ) else $error("Result delivered without a spent credit");

    credits_bounded: assert property (
        @(posedge clk) disable iff (reset) in_flight <= CREDITS
    ) else $error("More words in flight than downstream credits");

    flags_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        out_valid |-> !(out_result.sbit_err && out_result.dbit_err)
    ) else $error("Single and double error flags both set");

endmodule

bind ecc_126_top ecc_126_top_sva #(
    .DEPTH   (IN_CREDITS),
    .CREDITS (OUT_CREDITS)
) sva_inst (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_result (out_result)
);

/* tb_ecc_126_top.sv */
`timescale 1ns/1ps

module tb_ecc_126_top;

    localparam int IN_CR      = ecc_pkg::DEFAULT_IN_CREDITS;
    localparam int OUT_CR     = ecc_pkg::DEFAULT_OUT_CREDITS;
    localparam int WAIT_LIMIT = 200;

    logic                 clk;
    logic                 reset;
    ecc_pkg::ecc_data_t   wr_data;
    ecc_pkg::ecc_parity_t wr_parity;
    logic                 in_valid;
    ecc_pkg::ecc_read_t   in_word;
    logic                 in_credit;
    logic                 out_credit;
    logic                 out_valid;
    ecc_pkg::ecc_result_t out_result;

    ecc_pkg::ecc_result_t expect_q[$];
    logic [31:0]          rng_state;
    int                   errors;
    int                   checks;
    int                   results_seen;
    int                   credit_pulses;
    int                   up_credits;

    ecc_126_top ecc_126_top_inst (
        .clk        (clk),
        .reset      (reset),
        .wr_data    (wr_data),
        .wr_parity  (wr_parity),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ******************************************************************
    // Random numbers and reference code
    // ******************************************************************
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int rand_below(input int n);
        return int'(xorshift32() % n);
    endfunction

    function automatic ecc_pkg::ecc_data_t random_data();
        logic [127:0] r;
        r = {xorshift32(), xorshift32(), xorshift32(), xorshift32()};
        return ecc_pkg::ecc_data_t'(r);
    endfunction

    // Walk Hamming positions from 3, skipping powers of two
    function automatic ecc_pkg::ecc_parity_t ref_parity(input ecc_pkg::ecc_data_t d);
        ecc_pkg::ecc_parity_t p;
        int pos;
        int idx;
        p = '0;
        pos = 3;
        idx = 0;
        while (idx < ecc_pkg::DATA_WIDTH) begin
            if ((pos & (pos - 1)) != 0) begin
                if (d[idx]) begin
                    for (int k = 0; k < 8; k++) begin
                        if (pos[k]) p[k] = ~p[k];
                    end
                    // Even weight positions feed the top check bit
                    if ($countones(pos) % 2 == 0) p[8] = ~p[8];
                end
                idx++;
            end
            pos++;
        end
        return p;
    endfunction

    function automatic ecc_pkg::ecc_read_t clean_word(input ecc_pkg::ecc_data_t d);
        return '{data: d, parity: ref_parity(d), bypass: 1'b0};
    endfunction

    // Index below DATA_WIDTH is a data bit, above it a check bit
    function automatic ecc_pkg::ecc_read_t flip_bit(input ecc_pkg::ecc_read_t w, input int idx);
        if (idx < ecc_pkg::DATA_WIDTH) w.data[idx] = ~w.data[idx];
        else w.parity[idx - ecc_pkg::DATA_WIDTH] = ~w.parity[idx - ecc_pkg::DATA_WIDTH];
        return w;
    endfunction

    // ******************************************************************
    // Checking and handshake helpers
    // ******************************************************************
    task automatic compare_value(input logic [135:0] actual, input logic [135:0] expected,
                                 input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic send_word(input ecc_pkg::ecc_read_t word);
        int waited;
        waited = 0;
        while (up_credits == 0) begin
            if (waited == WAIT_LIMIT) abort_on_timeout("an upstream credit");
            next_cycle();
            waited++;
        end
        up_credits--;
        in_valid = 1'b1;
        in_word  = word;
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic wait_results(input int target);
        int waited;
        waited = 0;
        while (results_seen < target) begin
            if (waited == WAIT_LIMIT) abort_on_timeout("a checked word");
            next_cycle();
            waited++;
        end
    endtask

    task automatic return_credit();
        out_credit = 1'b1;
        next_cycle();
        out_credit = 1'b0;
    endtask

    task automatic check_one(input ecc_pkg::ecc_read_t word, input ecc_pkg::ecc_result_t expected);
        int target;
        target = results_seen + 1;
        expect_q.push_back(expected);
        send_word(word);
        wait_results(target);
        return_credit();
    endtask

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!reset) begin
            if (in_credit) begin
                credit_pulses++;
                up_credits++;
            end
            if (out_valid) begin
                results_seen++;
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("A result arrived at %0t ns with no word outstanding", $time);
                end else begin
                    compare_value(out_result, expect_q.pop_front(), "read result");
                end
            end
        end
    end

    // ******************************************************************
    // Directed tests
    // ******************************************************************
    task automatic test_encode();
        ecc_pkg::ecc_data_t d;
        for (int i = 0; i < 20; i++) begin
            d = random_data();
            wr_data = d;
            next_cycle();
            compare_value(wr_parity, ref_parity(d), $sformatf("encode random %0d", i));
        end
        for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
            d = '0;
            d[i] = 1'b1;
            wr_data = d;
            next_cycle();
            compare_value(wr_parity, ref_parity(d), $sformatf("encode bit %0d", i));
        end
    endtask

    task automatic test_clean();
        ecc_pkg::ecc_data_t d;
        for (int i = 0; i < 8; i++) begin
            d = random_data();
            check_one(clean_word(d), '{data: d, sbit_err: 1'b0, dbit_err: 1'b0});
        end
    endtask

    task automatic test_single();
        ecc_pkg::ecc_data_t d;
        for (int i = 0; i < 8; i++) begin
            d = random_data();
            check_one(flip_bit(clean_word(d), rand_below(ecc_pkg::DATA_WIDTH)),
                      '{data: d, sbit_err: 1'b1, dbit_err: 1'b0});
        end
        for (int k = 0; k < ecc_pkg::PARITY_WIDTH; k++) begin
            d = random_data();
            check_one(flip_bit(clean_word(d), ecc_pkg::DATA_WIDTH + k),
                      '{data: d, sbit_err: 1'b1, dbit_err: 1'b0});
        end
    endtask

    task automatic test_double();
        ecc_pkg::ecc_read_t   w;
        ecc_pkg::ecc_parity_t syn;
        int a;
        int b;
        for (int i = 0; i < 12; i++) begin
            a = rand_below(ecc_pkg::DATA_WIDTH + ecc_pkg::PARITY_WIDTH);
            b = (a + 1 + rand_below(ecc_pkg::DATA_WIDTH + ecc_pkg::PARITY_WIDTH - 1))
                % (ecc_pkg::DATA_WIDTH + ecc_pkg::PARITY_WIDTH);
            w = flip_bit(flip_bit(clean_word(random_data()), a), b);
            // Syndrome as the write encoder sees the received data
            wr_data = w.data;
            next_cycle();
            syn = w.parity ^ wr_parity;
            compare_value(syn != '0 && $countones(syn) % 2 == 0, 1'b1,
                          $sformatf("even syndrome for bits %0d and %0d", a, b));
            check_one(w, '{data: w.data, sbit_err: 1'b0, dbit_err: 1'b1});
        end
    endtask

    task automatic test_bypass();
        ecc_pkg::ecc_read_t w;
        for (int i = 0; i < 6; i++) begin
            w = flip_bit(clean_word(random_data()), rand_below(ecc_pkg::DATA_WIDTH));
            if (i % 2 == 1) w = flip_bit(w, ecc_pkg::DATA_WIDTH + rand_below(9));
            w.bypass = 1'b1;
            check_one(w, '{data: w.data, sbit_err: 1'b0, dbit_err: 1'b0});
        end
    endtask

    task automatic test_credits();
        ecc_pkg::ecc_data_t d;
        int res_base;
        int pulse_base;
        int target;
        res_base   = results_seen;
        pulse_base = credit_pulses;
        for (int i = 0; i < IN_CR; i++) begin
            d = random_data();
            expect_q.push_back('{data: d, sbit_err: 1'b0, dbit_err: 1'b0});
            send_word(clean_word(d));
        end
        wait_results(res_base + OUT_CR);
        // Nothing more may leave while downstream credits are held back
        repeat (10) next_cycle();
        compare_value(results_seen - res_base, OUT_CR, "results with credits held");
        compare_value(credit_pulses - pulse_base, OUT_CR, "in_credit pulses with credits held");
        for (int i = 0; i < IN_CR; i++) begin
            return_credit();
            target = (OUT_CR + i + 1 < IN_CR) ? OUT_CR + i + 1 : IN_CR;
            wait_results(res_base + target);
        end
        repeat (4) next_cycle();
        compare_value(credit_pulses - pulse_base, IN_CR, "in_credit pulses in total");
    endtask

    initial begin
        reset         = 1'b1;
        wr_data       = '0;
        in_valid      = 1'b0;
        in_word       = '0;
        out_credit    = 1'b0;
        rng_state     = 32'd99764;
        errors        = 0;
        checks        = 0;
        results_seen  = 0;
        credit_pulses = 0;
        up_credits    = IN_CR;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();

        test_encode();
        test_clean();
        test_single();
        test_double();
        test_bypass();
        test_credits();

        repeat (5) next_cycle();
        if (expect_q.size() != 0) begin
            errors++;
            $display("%0d words were sent but never came back", expect_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* ecc_126.f */
ecc_pkg.sv
ecc_encoder.sv
ecc_syndrome_decoder.sv
ecc_credit_fifo.sv
ecc_check_pipe.sv
ecc_126_top.sv
ecc_126_top_sva.sv
tb_ecc_126_top.sv

/* Bender.yml */
package:
  name: ecc_126

sources:
  - ecc_pkg.sv
  - ecc_encoder.sv
  - ecc_syndrome_decoder.sv
  - ecc_credit_fifo.sv
  - ecc_check_pipe.sv
  - ecc_126_top.sv
  - target: test
    files:
      - ecc_126_top_sva.sv
      - tb_ecc_126_top.sv
